// File: mmu_top.f
verilog/bus_pkg.sv
verilog/vm_pkg.sv
verilog/bus_arbiter.sv
verilog/page_table_walker.sv
verilog/tlb.sv
verilog/mmu_top.sv
tests/mmu_tb_memory.sv
tests/mmu_tb.sv

// File: Bender.yml
package:
  name: mmu

sources:
  - files:
      - verilog/bus_pkg.sv
      - verilog/vm_pkg.sv
      - verilog/bus_arbiter.sv
      - verilog/page_table_walker.sv
      - verilog/tlb.sv
      - verilog/mmu_top.sv

  - target: test
    files:
      - tests/mmu_tb_memory.sv
      - tests/mmu_tb.sv

// File: tests/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;
    import bus_pkg::*;
    import vm_pkg::*;

    localparam int TLB_ENTRIES = 4;
    localparam int N_PAGES = 10;
    localparam int N_TRANS = 200;
    localparam int MAX_CYCLES = N_TRANS * 400 + 1000;
    localparam int SEED = 79756;
    localparam bus_data_t PTBR = 64'h0000_0000_0008_0000;
    localparam bus_tag_t READ_TAG = {SYSBUS_READ, SYSBUS_MEMORY, 8'h00};

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    logic         translate_valid = 1'b0;
    virt_addr_t   virt_addr = '0;
    bus_data_t    ptbr = PTBR;
    logic         flush = 1'b0;
    logic         ready;
    logic         translate_done;
    translation_t result;
    logic         main_bus_reqcyc;
    bus_req_t     main_bus_req;
    logic         main_bus_respcyc;
    bus_resp_t    main_bus_resp;
    logic         main_bus_respack;
    logic         client_reqcyc = 1'b0;
    logic         client_busy = 1'b0;
    logic         client_grant;

    integer       seed = SEED;
    int           errors = 0;
    int           cycles = 0;
    int           busy_left = 0;
    ppn_t         next_table = 44'h100;  // Table pages are handed out upward from here.
    vpn_t         pages [$];
    bus_data_t    leaf_page [bit [35:0]];
    bit           faults [bit [35:0]];
    int           levels [bit [35:0]];
    bus_data_t    line_addr [bit [37:0]];
    bit [35:0]    slot_vpn [TLB_ENTRIES];
    bit           slot_valid [TLB_ENTRIES];
    int           rr_slot = 0;
    bus_req_t     exp_reqs [$];

    mmu_top #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .translate_valid(translate_valid),
        .virt_addr(virt_addr),
        .ptbr(ptbr),
        .flush(flush),
        .ready(ready),
        .translate_done(translate_done),
        .result(result),
        .main_bus_reqcyc(main_bus_reqcyc),
        .main_bus_req(main_bus_req),
        .main_bus_respcyc(main_bus_respcyc),
        .main_bus_resp(main_bus_resp),
        .main_bus_respack(main_bus_respack),
        .client_reqcyc(client_reqcyc),
        .client_busy(client_busy),
        .client_grant(client_grant)
    );

    mmu_tb_memory #(
        .SEED(SEED)
    ) u_memory (
        .clk(clk),
        .reset(reset),
        .main_bus_reqcyc(main_bus_reqcyc),
        .main_bus_req(main_bus_req),
        .main_bus_respcyc(main_bus_respcyc),
        .main_bus_resp(main_bus_resp)
    );

    always #10 clk = ~clk;

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_translation(input translation_t got, input translation_t exp);
        // A faulting walk has no meaningful address.
        if (got.fault !== exp.fault || (!exp.fault && got.paddr !== exp.paddr))
        begin
            report_error($sformatf("Fail result: got paddr %h fault %h, expected paddr %h fault %h",
                got.paddr, got.fault, exp.paddr, exp.fault));
        end
    endtask

    task automatic check_bus_req(input bus_req_t got, input bus_req_t exp);
        if (got !== exp)
        begin
            report_error($sformatf("Fail main_bus_req: got addr %h tag %h, expected addr %h tag %h",
                got.addr, got.tag, exp.addr, exp.tag));
        end
    endtask

    // Writes whatever entries this VPN's walk still lacks and records the expected walk.
    task automatic build_page(input vpn_t vpn, input int bad_level);
        bus_data_t base;
        bus_data_t addr;
        pte_t      pte;
        base = PTBR;
        levels[vpn] = PT_LEVELS;
        faults[vpn] = 1'b0;
        for (int lvl = 0; lvl < PT_LEVELS; lvl++)
        begin
            addr = base + {vpn[PT_LEVELS-1-lvl], 3'b000};
            line_addr[{vpn, 2'(lvl)}] = {addr[63:6], 6'b000000};
            if (!u_memory.has_word(addr))
            begin
                pte = '0;
                pte.valid = (lvl != bad_level);
                if (lvl == PT_LEVELS - 1 || lvl == bad_level)
                begin
                    pte.ppn = ppn_t'({$random(seed), $random(seed)});
                end
                else
                begin
                    pte.ppn = next_table;
                    next_table = next_table + 1'b1;
                end
                u_memory.write_word(addr, pte);
            end
            pte = u_memory.read_word(addr);
            if (!pte.valid)
            begin
                faults[vpn] = 1'b1;
                levels[vpn] = lvl + 1;
                break;
            end
            base = {8'h00, pte.ppn, 12'h000};
        end
        leaf_page[vpn] = base;
    endtask

    task automatic translate(input virt_addr_t va);
        bit [35:0]    key;
        bit           hit;
        int           waited;
        translation_t exp;
        bus_req_t     req;
        key = va.vpn;
        hit = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            if (slot_valid[i] && slot_vpn[i] == key)
            begin
                hit = 1'b1;
            end
        end
        if (!hit)
        begin
            for (int lvl = 0; lvl < levels[key]; lvl++)
            begin
                req.addr = line_addr[{key, 2'(lvl)}];
                req.tag = READ_TAG;
                exp_reqs.push_back(req);
            end
        end
        exp.fault = faults[key];
        exp.paddr = leaf_page[key] | 64'(va.offset);
        @(posedge clk);
        #1;
        if (!ready)
        begin
            report_error("ready was low although no translation was in flight");
        end
        translate_valid = 1'b1;
        virt_addr = va;
        @(posedge clk);
        #1;
        translate_valid = 1'b0;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!translate_done);
        if (hit && waited != 1)
        begin
            report_error("translate_done did not follow the strobe by one cycle on a TLB hit");
        end
        check_translation(result, exp);
        if (exp_reqs.size() != 0)
        begin
            report_error("a walk ended with fewer bus requests than its page tables call for");
        end
        if (!hit && !exp.fault)
        begin
            slot_vpn[rr_slot] = key;
            slot_valid[rr_slot] = 1'b1;
            rr_slot = (rr_slot + 1) % TLB_ENTRIES;
        end
    endtask

    task automatic flush_tlb();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            slot_valid[i] = 1'b0;
        end
        rr_slot = 0;
        @(negedge clk);                  // Keeps the next random draw off the client's edge.
    endtask

    // External client: random requests, then a short busy period after each grant.
    always @(posedge clk)
    begin
        #1;
        if (reset)
        begin
            client_reqcyc = 1'b0;
            client_busy = 1'b0;
            busy_left = 0;
        end
        else if (client_grant)
        begin
            if (client_busy)
            begin
                report_error("client_grant was given while the client was still busy");
            end
            client_reqcyc = 1'b0;
            client_busy = 1'b1;
            busy_left = 2 + ($unsigned($random(seed)) % 4);
        end
        else if (busy_left > 0)
        begin
            busy_left--;
            client_busy = (busy_left > 0);
        end
        else if (!client_reqcyc && ($random(seed) & 7) == 0)
        begin
            client_reqcyc = 1'b1;
        end
    end

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (main_bus_respcyc !== main_bus_respack)
            begin
                report_error("main_bus_respack did not line up with a response beat");
            end
            if (client_busy && main_bus_reqcyc)
            begin
                report_error("a walker request overlapped the client busy period");
            end
            if (main_bus_reqcyc)
            begin
                if (exp_reqs.size() == 0)
                begin
                    report_error("the walker issued a bus request that no TLB miss called for");
                end
                else
                begin
                    check_bus_req(main_bus_req, exp_reqs.pop_front());
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            report_error("timeout: the run went past its cycle limit");
        end
    end

    initial
    begin
        vpn_t       vpn;
        virt_addr_t va;
        int         r;
        va = '0;
        for (int i = 0; i < N_PAGES; i++)
        begin
            // Narrow upper fields make pages share their upper tables.
            do
            begin
                vpn = {9'($random(seed) & 1), 9'($random(seed) & 3),
                       9'($random(seed)), 9'($random(seed))};
            end
            while (leaf_page.exists(vpn));
            r = $random(seed) & 15;
            build_page(vpn, (r < 4) ? r : PT_LEVELS);
            pages.push_back(vpn);
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        for (int n = 0; n < N_TRANS; n++)
        begin
            r = $random(seed) & 15;
            if (r == 0)
            begin
                flush_tlb();
            end
            else
            begin
                if (r < 12 || n == 0)
                begin
                    va.vpn = pages[$unsigned($random(seed)) % N_PAGES];
                    va.offset = 12'($random(seed));
                    va.upper = {VA_UPPER_W{va.vpn[PT_LEVELS-1][VPN_FIELD_W-1]}};
                end
                translate(va);
            end
        end
        repeat (5) @(negedge clk);
        if (errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/mmu_tb_memory.sv
`timescale 1ns/1ps

module mmu_tb_memory
#(
    parameter int SEED = 1
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               main_bus_reqcyc,
    input  bus_pkg::bus_req_t  main_bus_req,
    output logic               main_bus_respcyc,
    output bus_pkg::bus_resp_t main_bus_resp
);
    import bus_pkg::*;

    bus_data_t words [bus_data_t];       // Sparse store keyed by byte address.
    bus_data_t line_addr;
    int        delay;
    integer    seed = SEED;

    function automatic bit has_word(input bus_data_t addr);
        return words.exists(addr);
    endfunction

    function automatic bus_data_t read_word(input bus_data_t addr);
        if (words.exists(addr))
        begin
            return words[addr];
        end
        return (addr ^ {addr[31:0], addr[63:32]}) & ~64'h1;   // Unwritten words are never valid.
    endfunction

    task automatic write_word(input bus_data_t addr, input bus_data_t data);
        words[addr] = data;
    endtask

    initial
    begin
        main_bus_respcyc = 1'b0;
        main_bus_resp = '0;
    end

    // One line per request, eight beats back to back after a short random delay.
    always @(posedge clk)
    begin
        #1;
        if (reset)
        begin
            main_bus_respcyc = 1'b0;
            main_bus_resp = '0;
        end
        else if (main_bus_reqcyc)
        begin
            line_addr = main_bus_req.addr;
            delay = 1 + ($unsigned($random(seed)) % 6);
            repeat (delay) @(posedge clk);
            #1;
            for (int beat = 0; beat < LINE_BEATS; beat++)
            begin
                main_bus_respcyc = 1'b1;
                main_bus_resp.data = read_word(line_addr + 64'(beat * 8));
                main_bus_resp.tag = {SYSBUS_READ, SYSBUS_MEMORY, 8'h00};
                @(posedge clk);
                #1;
            end
            main_bus_respcyc = 1'b0;
            main_bus_resp = '0;
        end
    end

endmodule

// File: verilog/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
#(
    parameter int TLB_ENTRIES = 4
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 translate_valid,
    input  vm_pkg::virt_addr_t   virt_addr,
    input  bus_pkg::bus_data_t   ptbr,
    input  logic                 flush,
    output logic                 ready,
    output logic                 translate_done,
    output vm_pkg::translation_t result,
    output logic                 main_bus_reqcyc,
    output bus_pkg::bus_req_t    main_bus_req,
    input  logic                 main_bus_respcyc,
    input  bus_pkg::bus_resp_t   main_bus_resp,
    output logic                 main_bus_respack,
    input  logic                 client_reqcyc,
    input  logic                 client_busy,
    output logic                 client_grant
);
    import vm_pkg::*;

    logic       walk_start;
    virt_addr_t walk_vaddr;
    logic       walk_done;
    logic       walk_fault;
    pte_t       walk_pte;
    logic       walker_reqcyc;
    logic       walker_grant;
    logic       walker_busy;

    tlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlb (
        .clk(clk),
        .reset(reset),
        .translate_valid(translate_valid),
        .flush(flush),
        .virt_addr(virt_addr),
        .walk_done(walk_done),
        .walk_fault(walk_fault),
        .walk_pte(walk_pte),
        .walk_start(walk_start),
        .walk_vaddr(walk_vaddr),
        .ready(ready),
        .translate_done(translate_done),
        .result(result)
    );

    page_table_walker u_walker (
        .clk(clk),
        .reset(reset),
        .walk_start(walk_start),
        .walk_vaddr(walk_vaddr),
        .ptbr(ptbr),
        .abtr_grant(walker_grant),
        .abtr_reqcyc(walker_reqcyc),
        .bus_busy(walker_busy),
        .main_bus_reqcyc(main_bus_reqcyc),
        .main_bus_req(main_bus_req),
        .main_bus_respcyc(main_bus_respcyc),
        .main_bus_resp(main_bus_resp),
        .main_bus_respack(main_bus_respack),
        .walk_done(walk_done),
        .walk_fault(walk_fault),
        .walk_pte(walk_pte)
    );

    bus_arbiter u_arbiter (
        .clk(clk),
        .reset(reset),
        .walker_reqcyc(walker_reqcyc),
        .walker_busy(walker_busy),
        .client_reqcyc(client_reqcyc),
        .client_busy(client_busy),
        .walker_grant(walker_grant),
        .client_grant(client_grant)
    );

endmodule

// File: verilog/tlb.sv
`timescale 1ns/1ps

module tlb
#(
    parameter int TLB_ENTRIES = 4
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 translate_valid,
    input  logic                 flush,
    input  vm_pkg::virt_addr_t   virt_addr,
    input  logic                 walk_done,
    input  logic                 walk_fault,
    input  vm_pkg::pte_t         walk_pte,
    output logic                 walk_start,
    output vm_pkg::virt_addr_t   walk_vaddr,
    output logic                 ready,
    output logic                 translate_done,
    output vm_pkg::translation_t result
);
    import vm_pkg::*;

    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    typedef struct packed {
        vpn_t vpn;
        ppn_t ppn;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        TLB_IDLE,
        TLB_LOOKUP,
        TLB_WALK,
        TLB_RESP
    } tlb_state_t;

    tlb_state_t             state;
    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [IDX_W-1:0]       rr_ptr;      // Next slot to refill.
    virt_addr_t             req_vaddr;
    translation_t           walk_result;
    logic                   hit;
    ppn_t                   hit_ppn;
    logic                   dup_vpn;
    logic                   refill;

    always_comb
    begin
        hit = 1'b0;
        hit_ppn = '0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            if (entry_valid[i] && entries[i].vpn == req_vaddr.vpn)
            begin
                hit = 1'b1;
                hit_ppn = entries[i].ppn;
            end
        end
    end

    // A faulting walk leaves the array untouched.
    assign refill = (state == TLB_WALK) && walk_done && !walk_fault;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= TLB_IDLE;
            entry_valid <= '0;
            rr_ptr <= '0;
        end
        else
        begin
            case (state)
                TLB_IDLE:
                    state <= translate_valid ? TLB_LOOKUP : TLB_IDLE;
                TLB_LOOKUP:
                    state <= hit ? TLB_IDLE : TLB_WALK;
                TLB_WALK:
                    state <= walk_done ? TLB_RESP : TLB_WALK;
                default:
                    state <= TLB_IDLE;
            endcase
            if (flush)
            begin
                entry_valid <= '0;
                rr_ptr <= '0;                     // Refill order restarts at slot zero.
            end
            else if (refill)
            begin
                entry_valid[rr_ptr] <= 1'b1;
                rr_ptr <= (rr_ptr == IDX_W'(TLB_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == TLB_IDLE && translate_valid)
        begin
            req_vaddr <= virt_addr;
        end
        if (refill)
        begin
            entries[rr_ptr] <= '{vpn: req_vaddr.vpn, ppn: walk_pte.ppn};
        end
        if (state == TLB_WALK && walk_done)
        begin
            walk_result <= '{paddr: to_paddr(walk_pte.ppn, req_vaddr.offset),
                             fault: walk_fault};
        end
    end

    assign ready = (state == TLB_IDLE);
    assign walk_start = (state == TLB_LOOKUP) && !hit;
    assign walk_vaddr = req_vaddr;
    assign translate_done = ((state == TLB_LOOKUP) && hit) || (state == TLB_RESP);

    always_comb
    begin
        if (state == TLB_RESP)
        begin
            result = walk_result;
        end
        else
        begin
            result = '{paddr: to_paddr(hit_ppn, req_vaddr.offset), fault: 1'b0};
        end
    end

    always_comb
    begin
        dup_vpn = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            for (int j = i + 1; j < TLB_ENTRIES; j++)
            begin
                if (entry_valid[i] && entry_valid[j] && entries[i].vpn == entries[j].vpn)
                begin
                    dup_vpn = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !dup_vpn);

endmodule

// File: verilog/page_table_walker.sv
`timescale 1ns/1ps

module page_table_walker
(
    input  logic               clk,
    input  logic               reset,
    input  logic               walk_start,
    input  vm_pkg::virt_addr_t walk_vaddr,
    input  bus_pkg::bus_data_t ptbr,
    input  logic               abtr_grant,
    output logic               abtr_reqcyc,
    output logic               bus_busy,
    output logic               main_bus_reqcyc,
    output bus_pkg::bus_req_t  main_bus_req,
    input  logic               main_bus_respcyc,
    input  bus_pkg::bus_resp_t main_bus_resp,
    output logic               main_bus_respack,
    output logic               walk_done,
    output logic               walk_fault,
    output vm_pkg::pte_t       walk_pte
);
    import bus_pkg::*;
    import vm_pkg::*;

    localparam int BEAT_W = $clog2(LINE_BEATS);
    localparam int LEVEL_W = $clog2(PT_LEVELS);
    localparam int LINE_OFF_W = PTE_SHIFT + BEAT_W;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(LINE_BEATS - 1);
    localparam logic [LEVEL_W-1:0] LAST_LEVEL = LEVEL_W'(PT_LEVELS - 1);
    localparam bus_tag_t READ_TAG = {SYSBUS_READ, SYSBUS_MEMORY, 8'h00};

    typedef enum logic [2:0] {
        ST_RESET,
        ST_BEGIN,
        ST_REQ,
        ST_WAIT,
        ST_RESP,
        ST_RESPEND,
        ST_DONE
    } walk_state_t;

    walk_state_t        state;
    walk_state_t        next_state;
    logic [LEVEL_W-1:0] level;           // Zero is the root table.
    logic [BEAT_W-1:0]  beat_cnt;
    logic [BEAT_W-1:0]  word_idx;
    virt_addr_t         vaddr_q;
    bus_data_t          table_base;
    bus_data_t          pte_addr;
    vpn_field_t         vpn_sel;
    pte_t               kept_pte;
    logic               fault_q;
    logic               beat_ok;
    logic               in_line;

    assign vpn_sel = vaddr_q.vpn[LAST_LEVEL - level];
    assign pte_addr = table_base
                    + {{(64 - VPN_FIELD_W - PTE_SHIFT){1'b0}}, vpn_sel, {PTE_SHIFT{1'b0}}};

    // Only beats tagged as a memory read belong to this walker.
    assign beat_ok = main_bus_respcyc && (main_bus_resp.tag == READ_TAG);
    assign in_line = (state == ST_WAIT) || (state == ST_RESP);

    always_comb
    begin
        next_state = state;
        case (state)
            ST_RESET:
                next_state = walk_start ? ST_BEGIN : ST_RESET;
            ST_BEGIN:
                next_state = abtr_grant ? ST_REQ : ST_BEGIN;
            ST_REQ:
                next_state = ST_WAIT;
            ST_WAIT:
                next_state = beat_ok ? ST_RESP : ST_WAIT;
            ST_RESP:
                next_state = (beat_ok && beat_cnt == LAST_BEAT) ? ST_RESPEND : ST_RESP;
            ST_RESPEND:
                next_state = (!kept_pte.valid || level == LAST_LEVEL) ? ST_DONE : ST_REQ;
            ST_DONE:
                next_state = ST_RESET;
            default:
                next_state = ST_RESET;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_RESET;
            level <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == ST_REQ)
            begin
                beat_cnt <= '0;
            end
            else if (in_line && beat_ok)
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (state == ST_RESET && walk_start)
            begin
                level <= '0;
            end
            else if (state == ST_RESPEND && next_state == ST_REQ)
            begin
                level <= level + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_RESET && walk_start)
        begin
            vaddr_q <= walk_vaddr;
            table_base <= ptbr;
        end
        else if (state == ST_RESPEND)
        begin
            table_base <= to_paddr(kept_pte.ppn, '0);   // Next table sits on a page boundary.
        end
        if (state == ST_REQ)
        begin
            word_idx <= pte_addr[PTE_SHIFT +: BEAT_W];
        end
        if (main_bus_respack && beat_cnt == word_idx)
        begin
            kept_pte <= pte_t'(main_bus_resp.data);
        end
        if (state == ST_RESPEND)
        begin
            fault_q <= !kept_pte.valid;
        end
    end

    assign abtr_reqcyc = (state == ST_BEGIN);
    assign bus_busy = (state == ST_REQ) || in_line || (state == ST_RESPEND);
    assign main_bus_reqcyc = (state == ST_REQ);
    assign main_bus_respack = in_line && beat_ok;

    always_comb
    begin
        main_bus_req = '0;
        if (main_bus_reqcyc)
        begin
            main_bus_req.addr = {pte_addr[63:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
            main_bus_req.tag = READ_TAG;
        end
    end

    assign walk_done = (state == ST_DONE);
    assign walk_fault = walk_done && fault_q;
    assign walk_pte = kept_pte;

    assert property (@(posedge clk) disable iff (reset) main_bus_respack |-> main_bus_respcyc);

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
(
    input  logic clk,
    input  logic reset,
    input  logic walker_reqcyc,
    input  logic walker_busy,
    input  logic client_reqcyc,
    input  logic client_busy,
    output logic walker_grant,
    output logic client_grant
);
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_WALKER,
        OWN_CLIENT
    } owner_t;

    owner_t owner;
    logic   owner_busy;
    logic   busy_seen;                   // Owner has raised busy since its grant.

    assign owner_busy = (owner == OWN_WALKER) ? walker_busy : client_busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            owner <= OWN_IDLE;
            busy_seen <= 1'b0;
            walker_grant <= 1'b0;
            client_grant <= 1'b0;
        end
        else
        begin
            walker_grant <= 1'b0;
            client_grant <= 1'b0;
            if (owner == OWN_IDLE)
            begin
                busy_seen <= 1'b0;
                if (!walker_busy && !client_busy)
                begin
                    if (walker_reqcyc)
                    begin
                        owner <= OWN_WALKER;      // Walker wins a tie.
                        walker_grant <= 1'b1;
                    end
                    else if (client_reqcyc)
                    begin
                        owner <= OWN_CLIENT;
                        client_grant <= 1'b1;
                    end
                end
            end
            else if (owner_busy)
            begin
                busy_seen <= 1'b1;
            end
            else if (busy_seen)
            begin
                owner <= OWN_IDLE;                // Busy has fallen, bus is free again.
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(walker_grant && client_grant));
    assert property (@(posedge clk) disable iff (reset) walker_grant |-> $past(!client_busy));
    assert property (@(posedge clk) disable iff (reset) client_grant |-> $past(!walker_busy));

endmodule

// File: verilog/vm_pkg.sv
package vm_pkg;

    localparam int PT_LEVELS = 4;
    localparam int VPN_FIELD_W = 9;
    localparam int PAGE_SHIFT = 12;
    localparam int PPN_W = 44;
    localparam int PTE_SHIFT = 3;        // Each entry is eight bytes.
    localparam int VA_UPPER_W = 64 - PT_LEVELS * VPN_FIELD_W - PAGE_SHIFT;

    typedef logic [VPN_FIELD_W-1:0] vpn_field_t;

    // Element PT_LEVELS-1 indexes the root table.
    typedef vpn_field_t [PT_LEVELS-1:0] vpn_t;

    typedef logic [PPN_W-1:0] ppn_t;

    typedef struct packed {
        logic [VA_UPPER_W-1:0] upper;    // Sign extension of bit 47.
        vpn_t                  vpn;
        logic [PAGE_SHIFT-1:0] offset;
    } virt_addr_t;

    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [8:0] flags;               // Permission bits, not checked here.
        logic       valid;
    } pte_t;

    typedef struct packed {
        logic [63:0] paddr;
        logic        fault;
    } translation_t;

    // Joins a physical page number and a page offset into a full address.
    function automatic logic [63:0] to_paddr(ppn_t ppn, logic [PAGE_SHIFT-1:0] offset);
        return {{(64 - PPN_W - PAGE_SHIFT){1'b0}}, ppn, offset};
    endfunction

endpackage

// File: verilog/bus_pkg.sv
package bus_pkg;

    localparam int BUS_DATA_W = 64;
    localparam int BUS_TAG_W = 13;
    localparam int LINE_BEATS = 8;       // One 64-byte line per read.

    typedef logic [BUS_DATA_W-1:0] bus_data_t;
    typedef logic [BUS_TAG_W-1:0] bus_tag_t;

    // The command sits in bit 12 and the device in bits 11 to 8.
    localparam logic SYSBUS_READ = 1'b1;
    localparam logic [3:0] SYSBUS_MEMORY = 4'b0001;

    typedef struct packed {
        bus_data_t addr;                 // Line address, low six bits zero.
        bus_tag_t  tag;
    } bus_req_t;

    typedef struct packed {
        bus_data_t data;                 // One beat of the line.
        bus_tag_t  tag;
    } bus_resp_t;

endpackage
